// File: cache/cacheController.sv
/* Data cache controller
   Hit check, store merge, LRU victim choice and the write-back/refill FSM
   driving an AXI4-Lite master, one word per transaction */
`timescale 1ns/1ps
`default_nettype none

module cacheController (
  input  logic clk,
  input  logic reset,
  input  cachePkg::cpuReqT cpuReq,
  output logic cpuReqReady,
  output cachePkg::cpuRespT cpuResp,
  output logic [cachePkg::setBits-1:0] set,
  output logic [1:0] wordSel,
  output logic [cachePkg::tagBits-1:0] tagIn,
  output logic [1:0] wayWrite,
  output logic fillWrite,
  output logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] fillData,
  output logic dirtyIn,
  output logic [3:0] byteMask,
  output logic [cachePkg::dataBits-1:0] writeData,
  input  cachePkg::wayStatusT way1,
  input  cachePkg::wayStatusT way2,
  input  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] victimBlock,
  input  logic currLru,
  output cachePkg::axiMasterOutT axiOut,
  input  cachePkg::axiMasterInT axiIn
);

  typedef enum logic [2:0] {idle, lookup, writeBack, refill, respond} stateT;

  stateT state;
  cachePkg::cpuReqT req;
  logic [1:0] beat;
  logic awValid;
  logic wValid;
  logic arValid;
  logic [cachePkg::dataBits-1:0] rdataReg;
  logic [3*cachePkg::dataBits-1:0] fillBuf;
  logic [cachePkg::tagBits-1:0] reqTag;
  logic [cachePkg::tagBits-1:0] victimTag;
  logic hit1;
  logic hit2;
  logic hit;
  logic victimDirty;
  logic bDone;
  logic rDone;
  logic lastBeat;

  // Address fields of the held request
  assign reqTag = req.addr[cachePkg::addrBits-1 -: cachePkg::tagBits];
  assign set = req.addr[cachePkg::offsetBits +: cachePkg::setBits];
  assign wordSel = req.addr[cachePkg::offsetBits-1 -: 2];

  assign hit1 = way1.valid && (way1.tag == reqTag);
  assign hit2 = way2.valid && (way2.tag == reqTag);
  assign hit = hit1 || hit2;

  // LRU bit set names way 1 as the victim
  assign victimTag = currLru ? way1.tag : way2.tag;
  assign victimDirty = currLru ? (way1.valid && way1.dirty) : (way2.valid && way2.dirty);

  assign bDone = (state == writeBack) && axiIn.bvalid;
  assign rDone = (state == refill) && axiIn.rvalid;
  assign lastBeat = (beat == 2'd3);

  assign cpuReqReady = (state == idle);
  assign cpuResp.valid = (state == respond);
  assign cpuResp.rdata = rdataReg;

  assign tagIn = reqTag;
  assign writeData = req.wdata;
  // Last beat goes straight into the fill
  assign fillData = {axiIn.rdata, fillBuf};

  // Way writes; every hit writes its way so the LRU bit follows
  always_comb begin
    wayWrite = 2'b00;
    fillWrite = 1'b0;
    dirtyIn = 1'b0;
    byteMask = '0;
    if (state == lookup && hit) begin
      wayWrite = {!hit1 && hit2, hit1};
      dirtyIn = req.write;
      byteMask = req.write ? req.byteMask : 4'b0000;
    end else if (rDone && lastBeat) begin
      wayWrite = currLru ? 2'b01 : 2'b10;
      fillWrite = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= idle;
      beat <= 2'd0;
      awValid <= 1'b0;
      wValid <= 1'b0;
      arValid <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (cpuReq.valid) begin
            state <= lookup;
          end
        end
        lookup: begin
          beat <= 2'd0;
          if (hit) begin
            state <= respond;
          end else if (victimDirty) begin
            state <= writeBack;
            awValid <= 1'b1;
            wValid <= 1'b1;
          end else begin
            state <= refill;
            arValid <= 1'b1;
          end
        end
        writeBack: begin
          if (awValid && axiIn.awready) begin
            awValid <= 1'b0;
          end
          if (wValid && axiIn.wready) begin
            wValid <= 1'b0;
          end
          if (bDone) begin
            beat <= beat + 2'd1;
            if (lastBeat) begin
              state <= refill;
              arValid <= 1'b1;
            end else begin
              awValid <= 1'b1;
              wValid <= 1'b1;
            end
          end
        end
        refill: begin
          if (arValid && axiIn.arready) begin
            arValid <= 1'b0;
          end
          if (rDone) begin
            beat <= beat + 2'd1;
            if (lastBeat) begin
              // Replay the request against the filled way
              state <= lookup;
            end else begin
              arValid <= 1'b1;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cpuReqReady && cpuReq.valid) begin
      req <= cpuReq;
    end
    if (state == lookup && hit) begin
      rdataReg <= hit1 ? way1.word : way2.word;
    end
    if (rDone && !lastBeat) begin
      fillBuf[beat*cachePkg::dataBits +: cachePkg::dataBits] <= axiIn.rdata;
    end
  end

  // Beats walk the block at offsets 0, 4, 8 and 12
  always_comb begin
    axiOut.aw.awvalid = awValid;
    axiOut.aw.awaddr = {victimTag, set, beat, 2'b00};
    axiOut.w.wvalid = wValid;
    axiOut.w.wdata = victimBlock[beat*cachePkg::dataBits +: cachePkg::dataBits];
    axiOut.w.wstrb = 4'b1111;
    axiOut.ar.arvalid = arValid;
    axiOut.ar.araddr = {reqTag, set, beat, 2'b00};
    axiOut.bready = (state == writeBack);
    axiOut.rready = (state == refill);
  end

endmodule

`default_nettype wire

// File: cache/cacheMemory.sv
/* Cache memory
   Two ways with a per-set LRU table; exports both lookups and the victim block */
`timescale 1ns/1ps
`default_nettype none

module cacheMemory (
  input  logic clk,
  input  logic reset,
  input  logic [cachePkg::setBits-1:0] set,
  input  logic [1:0] wordSel,
  input  logic [1:0] wayWrite,
  input  logic fillWrite,
  input  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] fillData,
  input  logic [cachePkg::tagBits-1:0] tagIn,
  input  logic dirtyIn,
  input  logic [3:0] byteMask,
  input  logic [cachePkg::dataBits-1:0] writeData,
  output cachePkg::wayStatusT way1,
  output cachePkg::wayStatusT way2,
  output logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] victimBlock,
  output logic currLru
);

  logic [cachePkg::numSets-1:0] lruBits;
  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] way1Block;
  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] way2Block;

  // Bit set means way 2 was used last, so way 1 is the LRU way
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (|wayWrite) begin
      lruBits[set] <= wayWrite[1];
    end
  end

  assign currLru = lruBits[set];

  cacheWay way1_i (
    .clk(clk), .reset(reset), .set(set), .wordSel(wordSel),
    .writeEnable(wayWrite[0]), .fillWrite(fillWrite), .fillData(fillData),
    .tagIn(tagIn), .dirtyIn(dirtyIn), .byteMask(byteMask),
    .writeData(writeData), .status(way1), .block(way1Block)
  );

  cacheWay way2_i (
    .clk(clk), .reset(reset), .set(set), .wordSel(wordSel),
    .writeEnable(wayWrite[1]), .fillWrite(fillWrite), .fillData(fillData),
    .tagIn(tagIn), .dirtyIn(dirtyIn), .byteMask(byteMask),
    .writeData(writeData), .status(way2), .block(way2Block)
  );

  // Victim is the least recently used way of this set
  assign victimBlock = currLru ? way1Block : way2Block;

endmodule

`default_nettype wire

// File: cache/cacheWay.sv
/* Cache way
   Valid, dirty, tag and block storage of one way, with byte-masked
   word stores and whole-block refill */
`timescale 1ns/1ps
`default_nettype none

module cacheWay (
  input  logic clk,
  input  logic reset,
  input  logic [cachePkg::setBits-1:0] set,
  input  logic [1:0] wordSel,
  input  logic writeEnable,
  input  logic fillWrite,
  input  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] fillData,
  input  logic [cachePkg::tagBits-1:0] tagIn,
  input  logic dirtyIn,
  input  logic [3:0] byteMask,
  input  logic [cachePkg::dataBits-1:0] writeData,
  output cachePkg::wayStatusT status,
  output logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] block
);

  logic [cachePkg::numSets-1:0] validBits;
  logic [cachePkg::numSets-1:0] dirtyBits;
  logic [cachePkg::tagBits-1:0] tags [cachePkg::numSets];
  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] blocks [cachePkg::numSets];
  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] mergedBlock;

  // Status bits per set
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (writeEnable) begin
      if (fillWrite) begin
        validBits[set] <= 1'b1;
        dirtyBits[set] <= dirtyIn;
      end else begin
        // A read hit passes dirtyIn low and keeps the line dirty
        dirtyBits[set] <= dirtyBits[set] | dirtyIn;
      end
    end
  end

  // Current block with the store bytes laid over the selected word
  always_comb begin
    mergedBlock = blocks[set];
    for (int b = 0; b < 4; b++) begin
      if (byteMask[b]) begin
        mergedBlock[wordSel*cachePkg::dataBits + b*8 +: 8] = writeData[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (writeEnable) begin
      if (fillWrite) begin
        blocks[set] <= fillData;
        tags[set] <= tagIn;
      end else begin
        blocks[set] <= mergedBlock;
      end
    end
  end

  // Combinational lookup of the addressed set
  assign block = blocks[set];

  always_comb begin
    status.valid = validBits[set];
    status.dirty = dirtyBits[set];
    status.tag = tags[set];
    status.word = block[wordSel*cachePkg::dataBits +: cachePkg::dataBits];
  end

endmodule

`default_nettype wire

// File: common/cachePkg.sv
/* Data cache package
   Cache geometry, CPU request and response bundles, AXI4-Lite channels */
`default_nettype none

package cachePkg;

  // Geometry of the two-way cache
  localparam int addrBits = 32;
  localparam int dataBits = 32;
  localparam int wordsPerBlock = 4;
  localparam int offsetBits = 4;
  localparam int numSets = 64;
  localparam int setBits = 6;
  localparam int tagBits = 22;

  typedef struct packed {
    logic valid;
    logic write;
    logic [addrBits-1:0] addr;
    logic [dataBits-1:0] wdata;
    logic [dataBits/8-1:0] byteMask;
  } cpuReqT;

  typedef struct packed {
    logic valid;
    logic [dataBits-1:0] rdata;
  } cpuRespT;

  // AXI4-Lite master channels
  typedef struct packed {
    logic awvalid;
    logic [addrBits-1:0] awaddr;
  } axiAwT;

  typedef struct packed {
    logic wvalid;
    logic [dataBits-1:0] wdata;
    logic [dataBits/8-1:0] wstrb;
  } axiWT;

  typedef struct packed {
    logic arvalid;
    logic [addrBits-1:0] araddr;
  } axiArT;

  typedef struct packed {
    axiAwT aw;
    axiWT w;
    axiArT ar;
    logic bready;
    logic rready;
  } axiMasterOutT;

  // Slave-driven side
  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    logic [dataBits-1:0] rdata;
    logic [1:0] rresp;
  } axiMasterInT;

  // Lookup result of one way
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [tagBits-1:0] tag;
    logic [dataBits-1:0] word;
  } wayStatusT;

endpackage

`default_nettype wire

// File: compile.f
common/cachePkg.sv
cache/cacheWay.sv
cache/cacheMemory.sv
cache/cacheController.sv
design/dataCacheTop.sv
tb/dataCache_assert.sv
tb/cacheChecker.sv
tb/dataCacheTb.sv

// File: design/dataCacheTop.sv
/* Data cache top level
   Controller and cache memory between the CPU port and the AXI4-Lite master */
`timescale 1ns/1ps
`default_nettype none

module dataCacheTop (
  input  logic clk,
  input  logic reset,
  input  cachePkg::cpuReqT cpuReq,
  output logic cpuReqReady,
  output cachePkg::cpuRespT cpuResp,
  output cachePkg::axiMasterOutT axiOut,
  input  cachePkg::axiMasterInT axiIn
);

  logic [cachePkg::setBits-1:0] set;
  logic [1:0] wordSel;
  logic [cachePkg::tagBits-1:0] tagIn;
  logic [1:0] wayWrite;
  logic fillWrite;
  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] fillData;
  logic dirtyIn;
  logic [3:0] byteMask;
  logic [cachePkg::dataBits-1:0] writeData;
  cachePkg::wayStatusT way1;
  cachePkg::wayStatusT way2;
  logic [cachePkg::wordsPerBlock*cachePkg::dataBits-1:0] victimBlock;
  logic currLru;

  cacheController controller_i (
    .clk(clk), .reset(reset), .cpuReq(cpuReq), .cpuReqReady(cpuReqReady),
    .cpuResp(cpuResp), .set(set), .wordSel(wordSel), .tagIn(tagIn),
    .wayWrite(wayWrite), .fillWrite(fillWrite), .fillData(fillData),
    .dirtyIn(dirtyIn), .byteMask(byteMask), .writeData(writeData),
    .way1(way1), .way2(way2), .victimBlock(victimBlock), .currLru(currLru),
    .axiOut(axiOut), .axiIn(axiIn)
  );

  cacheMemory memory_i (
    .clk(clk), .reset(reset), .set(set), .wordSel(wordSel),
    .wayWrite(wayWrite), .fillWrite(fillWrite), .fillData(fillData),
    .tagIn(tagIn), .dirtyIn(dirtyIn), .byteMask(byteMask),
    .writeData(writeData), .way1(way1), .way2(way2),
    .victimBlock(victimBlock), .currLru(currLru)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dataCacheTb -f compile.f -o simv

status=0
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit $status

// File: tb/cacheChecker.sv
/* Data cache checker
   Reference memory and two-way LRU model; compares CPU responses and
   AXI write-back traffic */
`timescale 1ns/1ps
`default_nettype none

module cacheChecker (
  input  logic clk,
  input  logic reset,
  input  cachePkg::cpuReqT cpuReq,
  input  logic cpuReqReady,
  input  cachePkg::cpuRespT cpuResp,
  input  cachePkg::axiMasterOutT axiOut,
  input  cachePkg::axiMasterInT axiIn,
  input  logic [127:0] testName,
  output int mismatchCount,
  output int protocolCount
);

  logic [31:0] refMem [logic [29:0]];
  logic [21:0] tagModel [2][64];
  logic validModel [2][64];
  logic dirtyModel [2][64];
  logic lruModel [64];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] awQ [$];
  logic [31:0] wQ [$];
  logic pending;
  logic pendingRead;
  logic [31:0] expRead;
  logic expectHit;
  int respWait;

  // Untouched words follow the memory's initial pattern
  function automatic logic [31:0] refRead(input logic [31:0] a);
    if (refMem.exists(a[31:2])) begin
      return refMem[a[31:2]];
    end
    return {a[31:2], 2'b00} ^ 32'hC0DE0000;
  endfunction

  task automatic modelRequest(input cachePkg::cpuReqT r);
    logic [5:0] s;
    logic [21:0] t;
    logic [31:0] a;
    logic [31:0] word;
    int way;
    s = r.addr[9:4];
    t = r.addr[31:10];
    way = -1;
    for (int w = 0; w < 2; w++) begin
      if (validModel[w][s] && tagModel[w][s] == t) begin
        way = w;
      end
    end
    expectHit = (way >= 0);
    respWait = 0;
    if (way < 0) begin
      // LRU bit set means way 2 was used last
      way = lruModel[s] ? 0 : 1;
      if (validModel[way][s] && dirtyModel[way][s]) begin
        for (int k = 0; k < 4; k++) begin
          a = {tagModel[way][s], s, k[1:0], 2'b00};
          expAddr.push_back(a);
          expData.push_back(refRead(a));
        end
      end
      tagModel[way][s] = t;
      validModel[way][s] = 1'b1;
      dirtyModel[way][s] = 1'b0;
    end
    lruModel[s] = (way == 1);
    pendingRead = !r.write;
    if (r.write) begin
      dirtyModel[way][s] = 1'b1;
      word = refRead(r.addr);
      for (int b = 0; b < 4; b++) begin
        if (r.byteMask[b]) begin
          word[b*8 +: 8] = r.wdata[b*8 +: 8];
        end
      end
      refMem[r.addr[31:2]] = word;
    end else begin
      expRead = refRead(r.addr);
    end
    pending = 1'b1;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < 64; s++) begin
        validModel[0][s] = 1'b0;
        validModel[1][s] = 1'b0;
        dirtyModel[0][s] = 1'b0;
        dirtyModel[1][s] = 1'b0;
        lruModel[s] = 1'b0;
      end
      pending = 1'b0;
      mismatchCount = 0;
      protocolCount = 0;
    end else begin
      if (pending) begin
        respWait++;
      end
      // Between requests the DUT is idle and quiet on AXI
      if (cpuReqReady) begin
        if (pending) begin
          protocolCount++;
          $display("cpuReqReady high while a request is in flight in %0s", testName);
        end
        if (axiOut.aw.awvalid || axiOut.w.wvalid || axiOut.ar.arvalid ||
            axiOut.bready || axiOut.rready || cpuResp.valid) begin
          protocolCount++;
          $display("AXI or response signal active while idle in %0s", testName);
        end
      end
      if (axiOut.aw.awvalid && axiIn.awready) begin
        awQ.push_back(axiOut.aw.awaddr);
      end
      if (axiOut.w.wvalid && axiIn.wready) begin
        wQ.push_back(axiOut.w.wdata);
        if (axiOut.w.wstrb !== 4'hF) begin
          mismatchCount++;
          $display("MISMATCH %0s wstrb expected %h actual %h", testName, 4'hF,
                   axiOut.w.wstrb);
        end
      end
      while (awQ.size() > 0 && wQ.size() > 0) begin
        if (expAddr.size() == 0) begin
          protocolCount++;
          $display("Unexpected write-back to address %h in %0s", awQ[0], testName);
        end else begin
          if (awQ[0] !== expAddr[0]) begin
            mismatchCount++;
            $display("MISMATCH %0s awaddr expected %h actual %h", testName, expAddr[0], awQ[0]);
          end
          if (wQ[0] !== expData[0]) begin
            mismatchCount++;
            $display("MISMATCH %0s wdata expected %h actual %h", testName, expData[0], wQ[0]);
          end
          void'(expAddr.pop_front());
          void'(expData.pop_front());
        end
        void'(awQ.pop_front());
        void'(wQ.pop_front());
      end
      if (cpuResp.valid) begin
        if (!pending) begin
          protocolCount++;
          $display("Response arrived without a request in %0s", testName);
        end else begin
          if (expAddr.size() != 0) begin
            protocolCount++;
            $display("Missing %0d write-back beats in %0s", expAddr.size(), testName);
            expAddr.delete();
            expData.delete();
          end
          if (pendingRead && cpuResp.rdata !== expRead) begin
            mismatchCount++;
            $display("MISMATCH %0s rdata expected %h actual %h", testName, expRead,
                     cpuResp.rdata);
          end
          if (expectHit && respWait != 2) begin
            mismatchCount++;
            $display("MISMATCH %0s hit latency expected 2 actual %0d", testName, respWait);
          end
        end
        pending = 1'b0;
      end
      if (cpuReqReady && cpuReq.valid) begin
        modelRequest(cpuReq);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/dataCacheTb.sv
/* Data cache testbench
   Clock, reset, AXI4-Lite memory model with ready delays and the stimulus table */
`timescale 1ns/1ps
`default_nettype none

module dataCacheTb;

  logic clk;
  logic reset;
  cachePkg::cpuReqT cpuReq;
  logic cpuReqReady;
  cachePkg::cpuRespT cpuResp;
  cachePkg::axiMasterOutT axiOut;
  cachePkg::axiMasterInT axiIn = '0;
  logic [127:0] testName;
  int mismatchCount;
  int protocolCount;
  int cycleCount;
  int timeoutLimit;
  logic randomDelays;

  logic [127:0] entryName [$];
  logic entryWrite [$];
  logic [31:0] entryAddr [$];
  logic [31:0] entryWdata [$];
  logic [3:0] entryMask [$];

  logic [31:0] mem [logic [29:0]];
  logic awGot;
  logic wGot;
  logic arGot;
  logic [31:0] awAddr;
  logic [31:0] arAddr;
  logic [31:0] wData;
  logic [3:0] wStrb;
  int awDelay;
  int wDelay;
  int arDelay;

  dataCacheTop dataCacheTop_i (
    .clk(clk), .reset(reset), .cpuReq(cpuReq), .cpuReqReady(cpuReqReady),
    .cpuResp(cpuResp), .axiOut(axiOut), .axiIn(axiIn)
  );

  cacheChecker checker_i (
    .clk(clk), .reset(reset), .cpuReq(cpuReq), .cpuReqReady(cpuReqReady),
    .cpuResp(cpuResp), .axiOut(axiOut), .axiIn(axiIn), .testName(testName),
    .mismatchCount(mismatchCount), .protocolCount(protocolCount)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int pickDelay();
    return randomDelays ? int'($urandom % 4) : 0;
  endfunction

  function automatic logic [31:0] memRead(input logic [31:0] a);
    if (mem.exists(a[31:2])) begin
      return mem[a[31:2]];
    end
    return {a[31:2], 2'b00} ^ 32'hC0DE0000;
  endfunction

  // AXI4-Lite slave with delayed readies and a response once the address is taken
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      axiIn <= '0;
      awGot <= 1'b0;
      wGot <= 1'b0;
      arGot <= 1'b0;
      awDelay <= 0;
      wDelay <= 0;
      arDelay <= 0;
    end else begin
      if (axiOut.aw.awvalid && !awGot) begin
        if (axiIn.awready) begin
          awGot <= 1'b1;
          awAddr <= axiOut.aw.awaddr;
          axiIn.awready <= 1'b0;
          awDelay <= pickDelay();
        end else if (awDelay == 0) begin
          axiIn.awready <= 1'b1;
        end else begin
          awDelay <= awDelay - 1;
        end
      end
      if (axiOut.w.wvalid && !wGot) begin
        if (axiIn.wready) begin
          wGot <= 1'b1;
          wData <= axiOut.w.wdata;
          wStrb <= axiOut.w.wstrb;
          axiIn.wready <= 1'b0;
          wDelay <= pickDelay();
        end else if (wDelay == 0) begin
          axiIn.wready <= 1'b1;
        end else begin
          wDelay <= wDelay - 1;
        end
      end
      if (awGot && wGot && !axiIn.bvalid) begin
        for (int b = 0; b < 4; b++) begin
          if (wStrb[b]) begin
            mem[awAddr[31:2]] = memRead(awAddr);
            mem[awAddr[31:2]][b*8 +: 8] = wData[b*8 +: 8];
          end
        end
        axiIn.bvalid <= 1'b1;
        axiIn.bresp <= 2'b00;
      end
      if (axiIn.bvalid && axiOut.bready) begin
        axiIn.bvalid <= 1'b0;
        awGot <= 1'b0;
        wGot <= 1'b0;
      end
      if (axiOut.ar.arvalid && !arGot) begin
        if (axiIn.arready) begin
          arGot <= 1'b1;
          arAddr <= axiOut.ar.araddr;
          axiIn.arready <= 1'b0;
          arDelay <= pickDelay();
        end else if (arDelay == 0) begin
          axiIn.arready <= 1'b1;
        end else begin
          arDelay <= arDelay - 1;
        end
      end
      if (arGot && !axiIn.rvalid) begin
        axiIn.rvalid <= 1'b1;
        axiIn.rdata <= memRead(arAddr);
        axiIn.rresp <= 2'b00;
      end
      if (axiIn.rvalid && axiOut.rready) begin
        axiIn.rvalid <= 1'b0;
        arGot <= 1'b0;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutLimit) begin
      $display("Timeout after %0d cycles while running %0s", cycleCount, testName);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic addEntry(input logic [127:0] name, input logic write,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] mask);
    entryName.push_back(name);
    entryWrite.push_back(write);
    entryAddr.push_back(addr);
    entryWdata.push_back(wdata);
    entryMask.push_back(mask);
  endtask

  task automatic runTable();
    for (int i = 0; i < entryName.size(); i++) begin
      testName <= entryName[i];
      cpuReq <= {1'b1, entryWrite[i], entryAddr[i], entryWdata[i], entryMask[i]};
      @(posedge clk);
      while (!cpuReqReady) begin
        @(posedge clk);
      end
      cpuReq.valid <= 1'b0;
      do begin
        @(posedge clk);
      end while (!cpuResp.valid);
    end
  endtask

  initial begin
    int total;
    void'($urandom(32'h545ee61b));
    reset = 1'b1;
    cpuReq = '0;
    testName = '0;
    cycleCount = 0;
    timeoutLimit = 100000;
    randomDelays = 1'b0;

    // Read miss, hits on the rest of the block, partial store
    addEntry("readMiss", 1'b0, 32'h0000_1000, 32'h0, 4'h0);
    addEntry("readHit1", 1'b0, 32'h0000_1004, 32'h0, 4'h0);
    // Stray store fields on a read must leave the word alone
    addEntry("readHit2", 1'b0, 32'h0000_1008, 32'hDEADBEEF, 4'hF);
    addEntry("readHit3", 1'b0, 32'h0000_100C, 32'h0, 4'h0);
    addEntry("partialStore", 1'b1, 32'h0000_1004, 32'hAABBCCDD, 4'b0101);
    addEntry("readMerged", 1'b0, 32'h0000_1004, 32'h0, 4'h0);
    // Two dirty lines in set 1, then a third
    addEntry("dirtyA", 1'b1, 32'h0000_2010, 32'h11111111, 4'hF);
    addEntry("dirtyB", 1'b1, 32'h0000_2418, 32'h22222222, 4'hF);
    addEntry("evictThird", 1'b0, 32'h0000_2810, 32'h0, 4'h0);
    addEntry("readA", 1'b0, 32'h0000_2010, 32'h0, 4'h0);
    addEntry("readB", 1'b0, 32'h0000_2418, 32'h0, 4'h0);
    // Clean eviction in set 2
    addEntry("cleanC", 1'b0, 32'h0000_3020, 32'h0, 4'h0);
    addEntry("cleanD", 1'b0, 32'h0000_3424, 32'h0, 4'h0);
    addEntry("cleanE", 1'b0, 32'h0000_3828, 32'h0, 4'h0);
    addEntry("refetchC", 1'b0, 32'h0000_302C, 32'h0, 4'h0);
    // LRU order A, B, A, C in set 3
    addEntry("lruA", 1'b1, 32'h0000_4030, 32'h33333333, 4'b1100);
    addEntry("lruB", 1'b1, 32'h0000_4434, 32'h44444444, 4'b0011);
    addEntry("lruA2", 1'b0, 32'h0000_4030, 32'h0, 4'h0);
    addEntry("lruC", 1'b0, 32'h0000_4838, 32'h0, 4'h0);
    addEntry("lruReadA", 1'b0, 32'h0000_4030, 32'h0, 4'h0);
    addEntry("lruReadB", 1'b0, 32'h0000_4434, 32'h0, 4'h0);
    timeoutLimit = 2 * entryName.size() * 60 + 100;

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    runTable();
    // Same table again with random ready delays
    randomDelays <= 1'b1;
    runTable();
    repeat (3) @(posedge clk);

    total = mismatchCount + protocolCount + dataCacheTop_i.assert_i.failCount;
    $display("Errors: mismatches=%0d protocol=%0d assertions=%0d", mismatchCount,
             protocolCount, dataCacheTop_i.assert_i.failCount);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/dataCache_assert.sv
/* Data cache protocol assertions
   AXI valid stability, one-cycle CPU response and OKAY-only responses */
`timescale 1ns/1ps
`default_nettype none

module dataCache_assert (
  input logic clk,
  input logic reset,
  input cachePkg::cpuRespT cpuResp,
  input cachePkg::axiMasterOutT axiOut,
  input cachePkg::axiMasterInT axiIn
);

  int failCount = 0;

  // A raised valid stays up until its ready
  awHeld: assert property (@(posedge clk) disable iff (reset)
    axiOut.aw.awvalid && !axiIn.awready |=> axiOut.aw.awvalid)
    else begin failCount++; $error("awvalid dropped before awready"); end

  wHeld: assert property (@(posedge clk) disable iff (reset)
    axiOut.w.wvalid && !axiIn.wready |=> axiOut.w.wvalid)
    else begin failCount++; $error("wvalid dropped before wready"); end

  arHeld: assert property (@(posedge clk) disable iff (reset)
    axiOut.ar.arvalid && !axiIn.arready |=> axiOut.ar.arvalid)
    else begin failCount++; $error("arvalid dropped before arready"); end

  respPulse: assert property (@(posedge clk) disable iff (reset)
    cpuResp.valid |=> !cpuResp.valid)
    else begin failCount++; $error("cpuResp.valid longer than one cycle"); end

  bOkay: assert property (@(posedge clk) disable iff (reset)
    axiIn.bvalid |-> axiIn.bresp == 2'b00)
    else begin failCount++; $error("write response not OKAY"); end

  rOkay: assert property (@(posedge clk) disable iff (reset)
    axiIn.rvalid |-> axiIn.rresp == 2'b00)
    else begin failCount++; $error("read response not OKAY"); end

endmodule

bind dataCacheTop dataCache_assert assert_i (
  .clk(clk), .reset(reset), .cpuResp(cpuResp), .axiOut(axiOut), .axiIn(axiIn)
);

`default_nettype wire
